//--- fcpu_mmu.f
rtl/fcpu_pkg.sv
rtl/mmu_request_queue.sv
rtl/mmu_control_fsm.sv
rtl/mmu_wait_counter.sv
rtl/mmu_cdb_buffer.sv
rtl/memory_management_unit.sv
verif/axi_mem_model.sv
verif/tb_fcpu_mmu.sv

//--- rtl/fcpu_pkg.sv
`default_nettype none

package fcpu_pkg;

   // Datapath and tag widths
   localparam int DATA_W   = 32;
   localparam int RSV_ID_W = 4;
   localparam int STRB_W   = DATA_W / 8;

   // Memory operations issued by the reservation stations
   typedef enum logic [1:0] {
      OP_LOAD_WORD,
      OP_LOAD_BYTE,
      OP_STORE_WORD
   } mmu_op_t;

   // Load/store control FSM
   typedef enum logic [2:0] {
      ST_IDLE,
      ST_CHECK,
      ST_READ_ADDR,
      ST_READ_WAIT,
      ST_WRITE_ADDR,
      ST_WRITE_WAIT,
      ST_RESULT
   } mmu_state_t;

   // Request from a reservation station
   typedef struct packed {
      logic [RSV_ID_W-1:0] rsv_id;
      mmu_op_t             opcode;
      logic [DATA_W-1:0]   address;
      logic [DATA_W-1:0]   data;
   } mmu_req_t;

   // Result broadcast on the CDB
   typedef struct packed {
      logic [RSV_ID_W-1:0] rsv_id;
      logic [DATA_W-1:0]   data;
      logic                err;
   } cdb_t;

   // Single-beat memory channels
   typedef struct packed {
      logic [DATA_W-1:0] addr;
   } mem_rd_req_t;

   typedef struct packed {
      logic [DATA_W-1:0] data;
      logic [1:0]        resp;
   } mem_rd_rsp_t;

   // Write address and data travel together
   typedef struct packed {
      logic [DATA_W-1:0] addr;
      logic [DATA_W-1:0] data;
      logic [STRB_W-1:0] strb;
   } mem_wr_req_t;

   typedef struct packed {
      logic [1:0] resp;
   } mem_wr_rsp_t;

endpackage

`default_nettype wire

//--- rtl/memory_management_unit.sv
`timescale 1ns/1ps
`default_nettype none

module memory_management_unit #(
   parameter int QUEUE_DEPTH    = 4,
   parameter int TIMEOUT_CYCLES = 32
) (
   input  wire                         clk,
   input  wire                         rst_n,
   // Requests from the reservation stations
   input  wire fcpu_pkg::mmu_req_t     req,
   input  wire                         req_valid,
   output logic                        req_ready,
   // Common data bus
   output fcpu_pkg::cdb_t              cdb,
   output logic                        cdb_valid,
   input  wire                         cdb_ready,
   // Data memory read
   output fcpu_pkg::mem_rd_req_t       mem_ar,
   output logic                        mem_ar_valid,
   input  wire                         mem_ar_ready,
   input  wire fcpu_pkg::mem_rd_rsp_t  mem_r,
   input  wire                         mem_r_valid,
   output logic                        mem_r_ready,
   // Data memory write
   output fcpu_pkg::mem_wr_req_t       mem_w,
   output logic                        mem_w_valid,
   input  wire                         mem_w_ready,
   input  wire fcpu_pkg::mem_wr_rsp_t  mem_b,
   input  wire                         mem_b_valid,
   output logic                        mem_b_ready
);

   import fcpu_pkg::*;

   // Queue to FSM
   mmu_req_t head;
   logic     head_valid;
   logic     pop;
   // FSM to counter
   logic     count_en;
   logic     timeout;
   // FSM to buffer
   cdb_t     result;
   logic     result_load;
   logic     full;

   mmu_request_queue #(
      .QUEUE_DEPTH (QUEUE_DEPTH)
   ) u_queue (
      .clk        (clk),
      .rst_n      (rst_n),
      .req        (req),
      .req_valid  (req_valid),
      .req_ready  (req_ready),
      .head       (head),
      .head_valid (head_valid),
      .pop        (pop)
   );

   mmu_control_fsm u_fsm (
      .clk          (clk),
      .rst_n        (rst_n),
      .head         (head),
      .head_valid   (head_valid),
      .pop          (pop),
      .count_en     (count_en),
      .timeout      (timeout),
      .result       (result),
      .result_load  (result_load),
      .full         (full),
      .mem_ar       (mem_ar),
      .mem_ar_valid (mem_ar_valid),
      .mem_ar_ready (mem_ar_ready),
      .mem_r        (mem_r),
      .mem_r_valid  (mem_r_valid),
      .mem_r_ready  (mem_r_ready),
      .mem_w        (mem_w),
      .mem_w_valid  (mem_w_valid),
      .mem_w_ready  (mem_w_ready),
      .mem_b        (mem_b),
      .mem_b_valid  (mem_b_valid),
      .mem_b_ready  (mem_b_ready)
   );

   // Response watchdog
   mmu_wait_counter #(
      .TIMEOUT_CYCLES (TIMEOUT_CYCLES)
   ) u_counter (
      .clk      (clk),
      .rst_n    (rst_n),
      .count_en (count_en),
      .timeout  (timeout)
   );

   mmu_cdb_buffer u_buffer (
      .clk         (clk),
      .rst_n       (rst_n),
      .result      (result),
      .result_load (result_load),
      .full        (full),
      .cdb         (cdb),
      .cdb_valid   (cdb_valid),
      .cdb_ready   (cdb_ready)
   );

endmodule

`default_nettype wire

//--- rtl/mmu_cdb_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module mmu_cdb_buffer (
   input  wire                  clk,
   input  wire                  rst_n,
   // From the control FSM
   input  wire fcpu_pkg::cdb_t  result,
   input  wire                  result_load,
   output logic                 full,
   // CDB side
   output fcpu_pkg::cdb_t       cdb,
   output logic                 cdb_valid,
   input  wire                  cdb_ready
);

   import fcpu_pkg::*;

   cdb_t held;
   logic held_valid;

   // Held result stays put until the CDB takes it
   always_ff @(posedge clk) begin
      if (result_load) begin
         held <= result;
      end
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         held_valid <= 1'b0;
      end else if (result_load) begin
         held_valid <= 1'b1;
      end else if (held_valid && cdb_ready) begin
         // Accepted this edge
         held_valid <= 1'b0;
      end
   end

   assign cdb       = held;
   assign cdb_valid = held_valid;
   // FSM stalls on this
   assign full      = held_valid;

endmodule

`default_nettype wire

//--- rtl/mmu_control_fsm.sv
`timescale 1ns/1ps
`default_nettype none

module mmu_control_fsm (
   input  wire                         clk,
   input  wire                         rst_n,
   // Request queue head
   input  wire fcpu_pkg::mmu_req_t     head,
   input  wire                         head_valid,
   output logic                        pop,
   // Wait counter
   output logic                        count_en,
   input  wire                         timeout,
   // Result buffer
   output fcpu_pkg::cdb_t              result,
   output logic                        result_load,
   input  wire                         full,
   // Read address and read data channels
   output fcpu_pkg::mem_rd_req_t       mem_ar,
   output logic                        mem_ar_valid,
   input  wire                         mem_ar_ready,
   input  wire fcpu_pkg::mem_rd_rsp_t  mem_r,
   input  wire                         mem_r_valid,
   output logic                        mem_r_ready,
   // Write and write response channels
   output fcpu_pkg::mem_wr_req_t       mem_w,
   output logic                        mem_w_valid,
   input  wire                         mem_w_ready,
   input  wire fcpu_pkg::mem_wr_rsp_t  mem_b,
   input  wire                         mem_b_valid,
   output logic                        mem_b_ready
);

   import fcpu_pkg::*;

   mmu_state_t        state;
   mmu_state_t        state_next;
   mmu_req_t          cur_req;
   logic [DATA_W-1:0] res_data;
   logic              res_err;
   logic              misaligned;
   logic [7:0]        load_byte;
   logic [DATA_W-1:0] load_data;

   // Word accesses need both low address bits clear
   assign misaligned = (head.opcode != OP_LOAD_BYTE) && (head.address[1:0] != 2'b00);

   // Byte lane picked by the low address bits
   assign load_byte = mem_r.data[{cur_req.address[1:0], 3'b000} +: 8];
   assign load_data = (cur_req.opcode == OP_LOAD_BYTE) ?
                      {{(DATA_W-8){1'b0}}, load_byte} : mem_r.data;

   // Next state
   always_comb begin
      state_next = state;
      case (state)
         ST_IDLE: begin
            if (head_valid) begin
               state_next = ST_CHECK;
            end
         end
         ST_CHECK: begin
            // Misaligned word access never reaches memory
            if (misaligned) begin
               state_next = ST_RESULT;
            end else if (head.opcode == OP_STORE_WORD) begin
               state_next = ST_WRITE_ADDR;
            end else begin
               state_next = ST_READ_ADDR;
            end
         end
         ST_READ_ADDR: begin
            if (timeout) begin
               state_next = ST_RESULT;
            end else if (mem_ar_ready) begin
               state_next = ST_READ_WAIT;
            end
         end
         ST_READ_WAIT: begin
            // A response in the timeout cycle still counts
            if (mem_r_valid || timeout) begin
               state_next = ST_RESULT;
            end
         end
         ST_WRITE_ADDR: begin
            if (timeout) begin
               state_next = ST_RESULT;
            end else if (mem_w_ready) begin
               state_next = ST_WRITE_WAIT;
            end
         end
         ST_WRITE_WAIT: begin
            if (mem_b_valid || timeout) begin
               state_next = ST_RESULT;
            end
         end
         ST_RESULT: begin
            // Hold until the buffer has room
            if (!full) begin
               state_next = ST_IDLE;
            end
         end
         default: begin
            state_next = ST_IDLE;
         end
      endcase
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         state <= ST_IDLE;
      end else begin
         state <= state_next;
      end
   end

   // Capture the head as it is popped
   always_ff @(posedge clk) begin
      if (state == ST_CHECK) begin
         cur_req <= head;
      end
   end

   // Result starts out as an error with zero data
   // Only a memory response overwrites it
   always_ff @(posedge clk) begin
      case (state)
         ST_CHECK: begin
            res_data <= '0;
            res_err  <= 1'b1;
         end
         ST_READ_WAIT: begin
            if (mem_r_valid) begin
               res_err  <= (mem_r.resp != 2'b00);
               res_data <= (mem_r.resp != 2'b00) ? '0 : load_data;
            end
         end
         ST_WRITE_WAIT: begin
            // Store data stays zero
            if (mem_b_valid) begin
               res_err <= (mem_b.resp != 2'b00);
            end
         end
         default: begin
            res_err <= res_err;
         end
      endcase
   end

   // Handshake controls
   assign pop          = (state == ST_CHECK);
   // Counter spans address and wait phases
   assign count_en     = (state == ST_READ_ADDR) || (state == ST_READ_WAIT) ||
                         (state == ST_WRITE_ADDR) || (state == ST_WRITE_WAIT);
   // Valid withdrawn once the timeout hits
   assign mem_ar_valid = (state == ST_READ_ADDR) && !timeout;
   assign mem_r_ready  = (state == ST_READ_WAIT);
   assign mem_w_valid  = (state == ST_WRITE_ADDR) && !timeout;
   assign mem_b_ready  = (state == ST_WRITE_WAIT);
   assign result_load  = (state == ST_RESULT) && !full;

   // Channel payloads
   always_comb begin
      // Byte loads read the whole word
      mem_ar.addr = {cur_req.address[DATA_W-1:2], 2'b00};
      mem_w.addr  = cur_req.address;
      mem_w.data  = cur_req.data;
      mem_w.strb  = '1;
   end

   // Tagged result
   always_comb begin
      result.rsv_id = cur_req.rsv_id;
      result.data   = res_data;
      result.err    = res_err;
   end

endmodule

`default_nettype wire

//--- rtl/mmu_request_queue.sv
`timescale 1ns/1ps
`default_nettype none

module mmu_request_queue #(
   parameter int QUEUE_DEPTH = 4
) (
   input  wire                      clk,
   input  wire                      rst_n,
   // Reservation-station side
   input  wire fcpu_pkg::mmu_req_t  req,
   input  wire                      req_valid,
   output logic                     req_ready,
   // Control FSM side
   output fcpu_pkg::mmu_req_t       head,
   output logic                     head_valid,
   input  wire                      pop
);

   import fcpu_pkg::*;

   localparam int PTR_W = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
   localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);

   mmu_req_t         entries [QUEUE_DEPTH];
   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] rd_ptr;
   logic [CNT_W-1:0] count;
   logic             push;
   logic             pull;

   // Circular increment, also correct for non power of two depths
   function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
      if (ptr == PTR_W'(QUEUE_DEPTH - 1)) begin
         return '0;
      end
      return ptr + 1'b1;
   endfunction

   // Ready drops only when every slot is taken
   assign req_ready  = (count != CNT_W'(QUEUE_DEPTH));
   assign head_valid = (count != '0);
   assign push       = req_valid && req_ready;
   // Pop of an empty queue is ignored
   assign pull       = pop && head_valid;

   // Oldest entry straight from storage
   assign head = entries[rd_ptr];

   // Entry storage
   always_ff @(posedge clk) begin
      if (push) begin
         entries[wr_ptr] <= req;
      end
   end

   // Pointers and occupancy
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (push) begin
            wr_ptr <= next_ptr(wr_ptr);
         end
         if (pull) begin
            rd_ptr <= next_ptr(rd_ptr);
         end
         // Push and pop together leave the count as is
         case ({push, pull})
            2'b10: begin
               count <= count + 1'b1;
            end
            2'b01: begin
               count <= count - 1'b1;
            end
            default: begin
               count <= count;
            end
         endcase
      end
   end

endmodule

`default_nettype wire

//--- rtl/mmu_wait_counter.sv
`timescale 1ns/1ps
`default_nettype none

module mmu_wait_counter #(
   parameter int TIMEOUT_CYCLES = 32
) (
   input  wire  clk,
   input  wire  rst_n,
   input  wire  count_en,
   output logic timeout
);

   localparam int CNT_W = $clog2(TIMEOUT_CYCLES + 1);

   logic [CNT_W-1:0] count;

   // Level while the count sits at the limit
   assign timeout = (count == CNT_W'(TIMEOUT_CYCLES));

   always_ff @(posedge clk) begin
      // Cleared whenever nothing is awaited
      if (!rst_n || !count_en) begin
         count <= '0;
      end else if (!timeout) begin
         count <= count + 1'b1;
      end
   end

endmodule

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
# Compile and run the fcpu_mmu testbench with Verilator

cd "$(dirname "$0")" || exit 1

OBJ_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert \
   --top-module tb_fcpu_mmu \
   -Mdir "$OBJ_DIR" \
   -f fcpu_mmu.f
if [ $? -ne 0 ]; then
   echo "Verilator compile failed"
   exit 1
fi

"./$OBJ_DIR/Vtb_fcpu_mmu" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if grep -q "^TESTBENCH PASSED$" "$LOG"; then
   echo "Run passed"
   exit 0
fi
echo "Run failed, see $LOG"
exit 1

//--- verif/axi_mem_model.sv
`timescale 1ns/1ps
`default_nettype none

module axi_mem_model #(
   parameter logic [31:0] SEED      = 32'h1,
   parameter logic [31:0] DEAD_BASE = 32'hF000_0000
) (
   input  wire                         clk,
   input  wire                         rst_n,
   // Read channels
   input  wire fcpu_pkg::mem_rd_req_t  ar,
   input  wire                         ar_valid,
   output logic                        ar_ready,
   output fcpu_pkg::mem_rd_rsp_t       r,
   output logic                        r_valid,
   input  wire                         r_ready,
   // Write channels
   input  wire fcpu_pkg::mem_wr_req_t  w,
   input  wire                         w_valid,
   output logic                        w_ready,
   output fcpu_pkg::mem_wr_rsp_t       b,
   output logic                        b_valid,
   input  wire                         b_ready
);

   import fcpu_pkg::*;

   // Sparse storage keyed by word index
   logic [31:0] words [logic [29:0]];
   logic [31:0] rng;
   logic        busy;
   logic        is_read;
   logic [2:0]  delay;
   logic [29:0] word_idx;

   function automatic logic [31:0] lcg_next(input logic [31:0] s);
      return s * 32'd1664525 + 32'd1013904223;
   endfunction

   // Unwritten words read back as their own address
   function automatic logic [31:0] read_word(input logic [29:0] idx);
      if (words.exists(idx)) begin
         return words[idx];
      end
      return {idx, 2'b00};
   endfunction

   // One transaction at a time
   assign ar_ready = !busy;
   assign w_ready  = !busy;

   // Strobed write, dead region dropped
   always @(posedge clk) begin
      logic [31:0] merged;
      if (rst_n && !busy && w_valid && (w.addr < DEAD_BASE)) begin
         merged = read_word(w.addr[31:2]);
         for (int i = 0; i < 4; i++) begin
            if (w.strb[i]) begin
               merged[8*i +: 8] = w.data[8*i +: 8];
            end
         end
         words[w.addr[31:2]] = merged;
      end
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         busy    <= 1'b0;
         is_read <= 1'b0;
         delay   <= '0;
         r_valid <= 1'b0;
         b_valid <= 1'b0;
         r       <= '0;
         b       <= '0;
         rng     <= SEED;
      end else if (!busy) begin
         // Addresses in the dead region are taken but never answered
         if (ar_valid && (ar.addr < DEAD_BASE)) begin
            busy     <= 1'b1;
            is_read  <= 1'b1;
            word_idx <= ar.addr[31:2];
            delay    <= 3'((rng >> 16) % 32'd6);
            rng      <= lcg_next(rng);
         end else if (w_valid && (w.addr < DEAD_BASE)) begin
            busy    <= 1'b1;
            is_read <= 1'b0;
            delay   <= 3'((rng >> 16) % 32'd6);
            rng     <= lcg_next(rng);
         end
      end else begin
         if (delay != 3'd0) begin
            delay <= delay - 3'd1;
         end else if (is_read && !r_valid) begin
            r_valid <= 1'b1;
            r.data  <= read_word(word_idx);
            r.resp  <= 2'b00;
         end else if (!is_read && !b_valid) begin
            b_valid <= 1'b1;
            b.resp  <= 2'b00;
         end
         // Response taken, back to idle
         if (r_valid && r_ready) begin
            r_valid <= 1'b0;
            busy    <= 1'b0;
         end
         if (b_valid && b_ready) begin
            b_valid <= 1'b0;
            busy    <= 1'b0;
         end
      end
   end

endmodule

`default_nettype wire

//--- verif/tb_fcpu_mmu.sv
`timescale 1ns/1ps
`default_nettype none

module tb_fcpu_mmu;

   import fcpu_pkg::*;

   localparam logic [31:0] SEED         = 32'h42d93e84;
   localparam int          NUM_REQS     = 400;
   localparam logic [31:0] DEAD_BASE    = 32'hF000_0000;
   localparam logic [31:0] WIN_BASE     = 32'h0000_1000;
   localparam int          ACCEPT_LIMIT = 1000;
   localparam int          DRAIN_LIMIT  = 5000;

   // Predicted result plus the behavior it belongs to
   typedef struct packed {
      cdb_t       res;
      logic [2:0] cat;
   } expect_t;

   logic clk;
   logic rst_n;
   mmu_req_t req;
   logic req_valid, req_ready;
   cdb_t cdb;
   logic cdb_valid, cdb_ready;
   mem_rd_req_t mem_ar;
   mem_rd_rsp_t mem_r;
   mem_wr_req_t mem_w;
   mem_wr_rsp_t mem_b;
   logic mem_ar_valid, mem_ar_ready, mem_r_valid, mem_r_ready;
   logic mem_w_valid, mem_w_ready, mem_b_valid, mem_b_ready;

   logic [31:0] stim_state;
   logic [31:0] ready_state;
   logic [31:0] ref_mem [logic [29:0]];
   expect_t     exp_q [$];
   int          errs [1:5];
   int          checks [1:5];
   int          accepted, results;
   logic        saw_full, hung;

   memory_management_unit #(
      .QUEUE_DEPTH    (4),
      .TIMEOUT_CYCLES (32)
   ) DUT (
      .clk (clk), .rst_n (rst_n),
      .req (req), .req_valid (req_valid), .req_ready (req_ready),
      .cdb (cdb), .cdb_valid (cdb_valid), .cdb_ready (cdb_ready),
      .mem_ar (mem_ar), .mem_ar_valid (mem_ar_valid), .mem_ar_ready (mem_ar_ready),
      .mem_r (mem_r), .mem_r_valid (mem_r_valid), .mem_r_ready (mem_r_ready),
      .mem_w (mem_w), .mem_w_valid (mem_w_valid), .mem_w_ready (mem_w_ready),
      .mem_b (mem_b), .mem_b_valid (mem_b_valid), .mem_b_ready (mem_b_ready)
   );

   axi_mem_model #(
      .SEED      (SEED ^ 32'h0000_ffff),
      .DEAD_BASE (DEAD_BASE)
   ) u_mem (
      .clk (clk), .rst_n (rst_n),
      .ar (mem_ar), .ar_valid (mem_ar_valid), .ar_ready (mem_ar_ready),
      .r (mem_r), .r_valid (mem_r_valid), .r_ready (mem_r_ready),
      .w (mem_w), .w_valid (mem_w_valid), .w_ready (mem_w_ready),
      .b (mem_b), .b_valid (mem_b_valid), .b_ready (mem_b_ready)
   );

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   function automatic logic [31:0] lcg_next(input logic [31:0] s);
      return s * 32'd1664525 + 32'd1013904223;
   endfunction

   // High LCG bits rotated down, low bits alone are weak
   task automatic stim_draw(output logic [31:0] v);
      stim_state = lcg_next(stim_state);
      v = {stim_state[15:0], stim_state[31:16]};
   endtask

   function automatic string behavior_name(input int k);
      case (k)
         1: return "word load/store";
         2: return "byte load";
         3: return "misaligned word";
         4: return "non-responding region";
         default: return "order, ids, back-pressure";
      endcase
   endfunction

   // Reference model, requests complete strictly in order
   function automatic expect_t predict(input mmu_req_t rq);
      expect_t     e;
      logic [31:0] w;
      e.res.rsv_id = rq.rsv_id;
      e.res.data   = '0;
      e.res.err    = 1'b0;
      if (rq.opcode != OP_LOAD_BYTE && rq.address[1:0] != 2'b00) begin
         e.res.err = 1'b1;
         e.cat     = 3'd3;
      end else if (rq.address >= DEAD_BASE) begin
         e.res.err = 1'b1;
         e.cat     = 3'd4;
      end else if (rq.opcode == OP_STORE_WORD) begin
         ref_mem[rq.address[31:2]] = rq.data;
         e.cat = 3'd1;
      end else begin
         w = ref_mem.exists(rq.address[31:2]) ? ref_mem[rq.address[31:2]] :
             {rq.address[31:2], 2'b00};
         if (rq.opcode == OP_LOAD_BYTE) begin
            e.res.data = {24'h0, w[8*rq.address[1:0] +: 8]};
            e.cat      = 3'd2;
         end else begin
            e.res.data = w;
            e.cat      = 3'd1;
         end
      end
      return e;
   endfunction

   task automatic check_result(input cdb_t got);
      expect_t e;
      results++;
      assert (exp_q.size() != 0) else begin
         $display("Error: CDB result at %0t with no request outstanding", $time);
         errs[5]++;
      end
      if (exp_q.size() != 0) begin
         e = exp_q.pop_front();
         checks[e.cat]++;
         checks[5]++;
         assert (got.rsv_id == e.res.rsv_id) else begin
            $display("FAILED at %0t: rsv_id %0h, expected %0h", $time, got.rsv_id,
                     e.res.rsv_id);
            errs[5]++;
         end
         assert (got.data == e.res.data && got.err == e.res.err) else begin
            $display("FAILED at %0t: id %0h data %08h err %0b, expected data %08h err %0b",
                     $time, got.rsv_id, got.data, got.err, e.res.data, e.res.err);
            errs[e.cat]++;
         end
      end
   endtask

   // CDB monitor and random cdb_ready
   initial begin
      logic [31:0] rb;
      cdb_ready   = 1'b0;
      ready_state = ~SEED;
      forever begin
         @(posedge clk);
         if (rst_n && cdb_valid && cdb_ready) begin
            check_result(cdb);
         end
         ready_state = lcg_next(ready_state);
         rb = {ready_state[15:0], ready_state[31:16]};
         cdb_ready <= (rb[1:0] != 2'b00);
      end
   end

   // Stimulus, drain and report
   initial begin
      mmu_req_t    rq;
      logic [31:0] v;
      int          waited;
      int          total;
      stim_state = SEED;
      req        = '0;
      req_valid  = 1'b0;
      rst_n      = 1'b0;
      accepted   = 0;
      results    = 0;
      saw_full   = 1'b0;
      hung       = 1'b0;
      for (int k = 1; k <= 5; k++) begin
         errs[k]   = 0;
         checks[k] = 0;
      end
      repeat (16) @(posedge clk);
      rst_n <= 1'b1;
      @(posedge clk);
      for (int i = 0; i < NUM_REQS && !hung; i++) begin
         stim_draw(v);
         // Occasional idle gap on req_valid
         if (v[15:14] == 2'b00) begin
            req_valid <= 1'b0;
            repeat (v[13:12]) @(posedge clk);
         end
         rq.opcode = mmu_op_t'(2'(v % 32'd3));
         rq.rsv_id = v[19:16];
         // 16-word window, one in sixteen in the dead region
         rq.address = (v[23:20] == 4'd0) ? DEAD_BASE : WIN_BASE;
         rq.address = rq.address | 32'({v[27:24], 2'b00});
         if (rq.opcode == OP_LOAD_BYTE || v[23:20] == 4'd1 || v[23:20] == 4'd2) begin
            rq.address[1:0] = v[29:28];
         end
         stim_draw(v);
         rq.data = v;
         req       <= rq;
         req_valid <= 1'b1;
         waited = 0;
         // req_ready only moves on rising edges, so mid-cycle shows the next edge
         @(negedge clk);
         while (!req_ready && waited < ACCEPT_LIMIT) begin
            saw_full = 1'b1;
            @(negedge clk);
            waited++;
         end
         if (req_ready) begin
            @(posedge clk);
            exp_q.push_back(predict(rq));
            accepted++;
         end else begin
            $display("Timeout: request %0d was never accepted", i);
            hung = 1'b1;
         end
      end
      req_valid <= 1'b0;
      waited = 0;
      while (!hung && exp_q.size() != 0 && waited < DRAIN_LIMIT) begin
         @(posedge clk);
         waited++;
      end
      if (!hung && exp_q.size() != 0) begin
         $display("Timeout: %0d results never reached the CDB", exp_q.size());
         hung = 1'b1;
      end
      // Quiet period to catch duplicated results
      repeat (50) @(posedge clk);
      assert (results == accepted) else begin
         $display("FAILED at %0t: %0d results for %0d accepted requests", $time, results,
                  accepted);
         errs[5]++;
      end
      assert (saw_full) else begin
         $display("Error: req_ready never fell while the unit was saturated");
         errs[5]++;
      end
      total = 0;
      for (int k = 1; k <= 5; k++) begin
         if (checks[k] == 0) begin
            $display("Error: behavior %0d was never exercised", k);
            errs[k]++;
         end
         $display("Behavior %0d (%s): %0d checks, %0d errors", k, behavior_name(k),
                  checks[k], errs[k]);
         total += errs[k];
      end
      $display("Totals: %0d accepted, %0d results, %0d errors", accepted, results, total);
      if (total == 0 && !hung) begin
         $display("TESTBENCH PASSED");
      end else begin
         $display("TESTBENCH FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire
